/* addr_pkg.sv */
/*
 * Address widths of the fetch front end
 * Typedefs for virtual and physical fetch addresses
 * Typedefs for page number and page offset fields
 */

package addr_pkg;

   parameter int VADDR_W = 32;
   parameter int PADDR_W = 32;
   parameter int PGOFS_W = 12;   // 4 KB pages

   // full addresses
   typedef logic [VADDR_W-1:0] vaddr_t;
   typedef logic [PADDR_W-1:0] paddr_t;

   // page fields, upper bits of each address
   typedef logic [VADDR_W-PGOFS_W-1:0] vpn_t;
   typedef logic [PADDR_W-PGOFS_W-1:0] ppn_t;

   // low bits, passed through translation untouched
   typedef logic [PGOFS_W-1:0] pgofs_t;

endpackage

/* tlb_pkg.sv */
/*
 * Instruction TLB definitions
 * Entry index type and the fetch address after reset
 */

package tlb_pkg;

   // table size limit the index type is built for
   parameter int TLB_MAX_ENTRIES = 16;

   typedef logic [$clog2(TLB_MAX_ENTRIES)-1:0] tlb_idx_t;

   // first fetch after reset
   parameter addr_pkg::vaddr_t RESET_PC = 32'h0000_1000;

endpackage

/* pc_gen.sv */
/*
 * Virtual fetch address generator
 * Registered valid follows fetch enable
 * Advances one instruction word per accepted transfer, reloads on redirect
 */

`timescale 1ns/1ps

module pc_gen (
   input  logic             clk_i,
   input  logic             rst_n_i,

   input  logic             fetch_en_i,

   input  logic             redirect_v_i,
   input  addr_pkg::vaddr_t redirect_pc_i,

   output logic             pc_v_o,
   output addr_pkg::vaddr_t pc_o,
   input  logic             pc_ready_i
);

   import addr_pkg::*;
   import tlb_pkg::*;

   localparam vaddr_t INSN_BYTES = vaddr_t'(4);

   vaddr_t pc_q;
   vaddr_t pc_d;
   logic   pc_v_q;
   logic   fire;

   assign fire = pc_v_q & pc_ready_i;   // itlb took the current pc

   // next address
   always_comb begin
      pc_d = pc_q;
      if (redirect_v_i) begin
         pc_d = redirect_pc_i;           // new target wins
      end else if (fire) begin
         pc_d = pc_q + INSN_BYTES;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         pc_q <= RESET_PC;
      end else begin
         pc_q <= pc_d;
      end
   end

   // valid is just enable delayed by a cycle
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         pc_v_q <= 1'b0;
      end else begin
         pc_v_q <= fetch_en_i;
      end
   end

   assign pc_v_o = pc_v_q;
   assign pc_o   = pc_q;

endmodule

/* itlb.sv */
/*
 * Fully associative instruction TLB
 * Parallel VPN compare against all entries, one-deep registered result
 * Fill with in-place update or round-robin replacement, flush clears all
 */

`timescale 1ns/1ps

module itlb #(
   parameter int N_ENTRIES = 4
) (
   input  logic             clk_i,
   input  logic             rst_n_i,

   input  logic             pc_v_i,
   input  addr_pkg::vaddr_t pc_i,
   output logic             pc_ready_o,

   input  logic             fill_v_i,
   input  addr_pkg::vpn_t   fill_vpn_i,
   input  addr_pkg::ppn_t   fill_ppn_i,
   input  logic             flush_i,

   output logic             tr_v_o,
   output addr_pkg::vaddr_t tr_vaddr_o,
   output addr_pkg::paddr_t tr_paddr_o,
   output logic             tr_miss_o,
   input  logic             tr_ready_i
);

   import addr_pkg::*;
   import tlb_pkg::*;

   // translation table
   logic [N_ENTRIES-1:0] valid_q;
   vpn_t                 vpn_q [N_ENTRIES];
   ppn_t                 ppn_q [N_ENTRIES];
   tlb_idx_t             victim_q;

   // lookup side
   vpn_t                 lk_vpn;
   pgofs_t               lk_ofs;
   logic [N_ENTRIES-1:0] lk_hit;
   ppn_t                 lk_ppn;
   logic                 lk_miss;

   // fill side
   logic [N_ENTRIES-1:0] fill_hit;
   logic [N_ENTRIES-1:0] fill_sel;
   logic                 fill_new;

   // output stage
   logic                 out_v_q;
   vaddr_t               out_vaddr_q;
   paddr_t               out_paddr_q;
   logic                 out_miss_q;
   logic                 accept;

   assign lk_vpn = pc_i[VADDR_W-1:PGOFS_W];
   assign lk_ofs = pc_i[PGOFS_W-1:0];

   always_comb begin
      lk_ppn = '0;
      for (int i = 0; i < N_ENTRIES; i++) begin
         lk_hit[i] = valid_q[i] && (vpn_q[i] == lk_vpn);
         if (lk_hit[i]) begin
            lk_ppn = lk_ppn | ppn_q[i];   // at most one entry matches
         end
      end
   end

   assign lk_miss = ~|lk_hit;

   // an existing mapping is updated in place, else the victim is replaced
   always_comb begin
      for (int i = 0; i < N_ENTRIES; i++) begin
         fill_hit[i] = valid_q[i] && (vpn_q[i] == fill_vpn_i);
      end
      fill_new = ~|fill_hit;
      for (int i = 0; i < N_ENTRIES; i++) begin
         fill_sel[i] = fill_new ? (tlb_idx_t'(i) == victim_q) : fill_hit[i];
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         valid_q  <= '0;
         victim_q <= '0;
      end else if (flush_i) begin
         valid_q  <= '0;             // flush beats fill
         victim_q <= '0;
      end else if (fill_v_i) begin
         valid_q <= valid_q | fill_sel;
         if (fill_new) begin
            victim_q <= (victim_q == tlb_idx_t'(N_ENTRIES - 1)) ? '0 : victim_q + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (fill_v_i && !flush_i) begin
         for (int i = 0; i < N_ENTRIES; i++) begin
            if (fill_sel[i]) begin
               vpn_q[i] <= fill_vpn_i;
               ppn_q[i] <= fill_ppn_i;
            end
         end
      end
   end

   // one item in flight, refilled while being drained
   assign pc_ready_o = !out_v_q || tr_ready_i;
   assign accept     = pc_v_i && pc_ready_o;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         out_v_q <= 1'b0;
      end else if (pc_ready_o) begin
         out_v_q <= pc_v_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept) begin
         out_vaddr_q <= pc_i;
         out_miss_q  <= lk_miss;
         out_paddr_q <= lk_miss ? '0 : {lk_ppn, lk_ofs};
      end
   end

   assign tr_v_o     = out_v_q;
   assign tr_vaddr_o = out_vaddr_q;
   assign tr_paddr_o = out_paddr_q;
   assign tr_miss_o  = out_miss_q;

endmodule

/* fetch_queue.sv */
/*
 * Fetch result FIFO
 * Circular buffer with read/write pointers and occupancy count
 * Valid/ready on both sides, head entry read combinationally
 */

`timescale 1ns/1ps

module fetch_queue #(
   parameter int Q_DEPTH = 4
) (
   input  logic             clk_i,
   input  logic             rst_n_i,

   input  logic             in_v_i,
   input  addr_pkg::vaddr_t in_vaddr_i,
   input  addr_pkg::paddr_t in_paddr_i,
   input  logic             in_miss_i,
   output logic             in_ready_o,

   output logic             out_v_o,
   output addr_pkg::vaddr_t out_vaddr_o,
   output addr_pkg::paddr_t out_paddr_o,
   output logic             out_miss_o,
   input  logic             out_ready_i
);

   import addr_pkg::*;

   localparam int ENTRY_W = VADDR_W + PADDR_W + 1;
   localparam int PTR_W   = (Q_DEPTH > 1) ? $clog2(Q_DEPTH) : 1;
   localparam int CNT_W   = $clog2(Q_DEPTH + 1);

   logic [ENTRY_W-1:0] mem_q [Q_DEPTH];
   logic [PTR_W-1:0]   wr_ptr_q;
   logic [PTR_W-1:0]   rd_ptr_q;
   logic [CNT_W-1:0]   count_q;
   logic [ENTRY_W-1:0] rd_entry;
   logic               wr_en;
   logic               rd_en;

   function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(Q_DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign in_ready_o = (count_q != CNT_W'(Q_DEPTH));   // low when full
   assign out_v_o    = (count_q != '0);
   assign wr_en      = in_v_i && in_ready_o;
   assign rd_en      = out_v_o && out_ready_i;

   always_ff @(posedge clk_i) begin
      if (wr_en) begin
         mem_q[wr_ptr_q] <= {in_vaddr_i, in_paddr_i, in_miss_i};
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr_q <= ptr_next(wr_ptr_q);
         end
         if (rd_en) begin
            rd_ptr_q <= ptr_next(rd_ptr_q);
         end
         case ({wr_en, rd_en})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;   // idle or pass-through
         endcase
      end
   end

   // head of queue, stable until taken
   assign rd_entry = mem_q[rd_ptr_q];
   assign {out_vaddr_o, out_paddr_o, out_miss_o} = rd_entry;

endmodule

/* fe_top.sv */
/*
 * Fetch front end top level
 * pc_gen -> itlb -> fetch_queue, valid/ready between stages
 */

`timescale 1ns/1ps

module fe_top #(
   parameter int N_ENTRIES = 4,
   parameter int Q_DEPTH   = 4
) (
   input  logic             clk_i,
   input  logic             rst_n_i,

   input  logic             fetch_en_i,
   input  logic             redirect_v_i,
   input  addr_pkg::vaddr_t redirect_pc_i,

   input  logic             fill_v_i,
   input  addr_pkg::vpn_t   fill_vpn_i,
   input  addr_pkg::ppn_t   fill_ppn_i,
   input  logic             flush_i,

   output logic             out_v_o,
   output addr_pkg::vaddr_t out_vaddr_o,
   output addr_pkg::paddr_t out_paddr_o,
   output logic             out_miss_o,
   input  logic             out_ready_i
);

   import addr_pkg::*;

   // pc_gen to itlb
   logic   pc_v;
   vaddr_t pc;
   logic   pc_ready;

   // itlb to queue
   logic   tr_v;
   vaddr_t tr_vaddr;
   paddr_t tr_paddr;
   logic   tr_miss;
   logic   tr_ready;

   pc_gen u_pc_gen (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .fetch_en_i    (fetch_en_i),
      .redirect_v_i  (redirect_v_i),
      .redirect_pc_i (redirect_pc_i),
      .pc_v_o        (pc_v),
      .pc_o          (pc),
      .pc_ready_i    (pc_ready)
   );

   itlb #(
      .N_ENTRIES (N_ENTRIES)
   ) u_itlb (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .pc_v_i     (pc_v),
      .pc_i       (pc),
      .pc_ready_o (pc_ready),
      .fill_v_i   (fill_v_i),
      .fill_vpn_i (fill_vpn_i),
      .fill_ppn_i (fill_ppn_i),
      .flush_i    (flush_i),
      .tr_v_o     (tr_v),
      .tr_vaddr_o (tr_vaddr),
      .tr_paddr_o (tr_paddr),
      .tr_miss_o  (tr_miss),
      .tr_ready_i (tr_ready)
   );

   fetch_queue #(
      .Q_DEPTH (Q_DEPTH)
   ) u_queue (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .in_v_i      (tr_v),
      .in_vaddr_i  (tr_vaddr),
      .in_paddr_i  (tr_paddr),
      .in_miss_i   (tr_miss),
      .in_ready_o  (tr_ready),
      .out_v_o     (out_v_o),
      .out_vaddr_o (out_vaddr_o),
      .out_paddr_o (out_paddr_o),
      .out_miss_o  (out_miss_o),
      .out_ready_i (out_ready_i)
   );

endmodule

/* fe_assert.sv */
/*
 * Protocol assertions for the fetch front end
 * Output hold under stall, queue bound, table updates only when idle
 */

`timescale 1ns/1ps

module fe_assert #(
   parameter int Q_DEPTH = 4
) (
   input  logic                           clk_i,
   input  logic                           rst_n_i,
   input  logic                           pc_v_i,
   input  logic                           fill_v_i,
   input  logic                           flush_i,
   input  logic                           out_v_i,
   input  addr_pkg::vaddr_t               out_vaddr_i,
   input  addr_pkg::paddr_t               out_paddr_i,
   input  logic                           out_miss_i,
   input  logic                           out_ready_i,
   input  logic [$clog2(Q_DEPTH+1)-1:0]   count_i
);

   a_out_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      out_v_i && !out_ready_i |=> out_v_i && $stable(out_vaddr_i)
         && $stable(out_paddr_i) && $stable(out_miss_i))
      else $error("fetch queue output changed while stalled");

   a_count_max: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      int'(count_i) <= Q_DEPTH)
      else $error("fetch queue count above depth");

   // table is only touched with fetch off
   a_idle_update: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      pc_v_i |-> !fill_v_i && !flush_i)
      else $error("fill or flush while pc valid");

endmodule

bind fe_top fe_assert #(
   .Q_DEPTH (Q_DEPTH)
) u_fe_assert (
   .clk_i       (clk_i),
   .rst_n_i     (rst_n_i),
   .pc_v_i      (pc_v),
   .fill_v_i    (fill_v_i),
   .flush_i     (flush_i),
   .out_v_i     (out_v_o),
   .out_vaddr_i (out_vaddr_o),
   .out_paddr_i (out_paddr_o),
   .out_miss_i  (out_miss_o),
   .out_ready_i (out_ready_i),
   .count_i     (u_queue.count_q)
);

/* tb_clkgen.sv */
/*
 * Testbench clock and reset
 * 10 ns clock, reset held low for the first cycles
 */

`timescale 1ns/1ps

module tb_clkgen #(
   parameter int RESET_CYCLES = 5
) (
   output logic clk_o,
   output logic rst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #5 clk_o = ~clk_o;
   end

   initial begin
      rst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      @(negedge clk_o);
      rst_n_o = 1'b1;   // released away from the sampling edge
   end

endmodule

/* tb_checker.sv */
/*
 * Testbench checker for the fetch front end
 * Model of the fetch address sequence and the TLB contents
 * Compares every accepted output, reports per test and in total
 */

`timescale 1ns/1ps

module tb_checker #(
   parameter int N_ENTRIES = 4
) (
   input  logic             clk_i,
   input  logic             rst_n_i,
   input  logic [2:0]       test_id_i,
   input  logic             done_i,
   input  logic             redirect_v_i,
   input  addr_pkg::vaddr_t redirect_pc_i,
   input  logic             fill_v_i,
   input  addr_pkg::vpn_t   fill_vpn_i,
   input  addr_pkg::ppn_t   fill_ppn_i,
   input  logic             flush_i,
   input  logic             out_v_i,
   input  addr_pkg::vaddr_t out_vaddr_i,
   input  addr_pkg::paddr_t out_paddr_i,
   input  logic             out_miss_i,
   input  logic             out_ready_i,
   output int               n_results_o,
   output int               n_errors_o
);

   import addr_pkg::*;
   import tlb_pkg::*;

   logic       m_valid [N_ENTRIES];
   vpn_t       m_vpn [N_ENTRIES];
   ppn_t       m_ppn [N_ENTRIES];
   int         m_victim;
   vaddr_t     exp_pc;
   logic [2:0] cur_test;
   int         test_results;
   int         test_errors;
   logic       closed;

   function automatic string test_name(input logic [2:0] id);
      case (id)
         3'd1:    return "miss_after_reset";
         3'd2:    return "fill_hit";
         3'd3:    return "round_robin_evict";
         3'd4:    return "refill_update";
         3'd5:    return "flush";
         3'd6:    return "backpressure";
         default: return "idle";
      endcase
   endfunction

   task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act) begin
         $display("CHECK FAILED %s %s expected %h actual %h",
                  test_name(cur_test), what, exp, act);
         test_errors++;
         n_errors_o++;
      end
   endtask

   task automatic check_output();
      logic   hit;
      ppn_t   ppn;
      paddr_t exp_paddr;
      hit = 1'b0;
      ppn = '0;
      for (int i = 0; i < N_ENTRIES; i++) begin
         if (m_valid[i] && m_vpn[i] == exp_pc[VADDR_W-1:PGOFS_W]) begin
            hit = 1'b1;
            ppn = m_ppn[i];
         end
      end
      exp_paddr = hit ? {ppn, exp_pc[PGOFS_W-1:0]} : '0;   // zero on a miss
      compare("vaddr", exp_pc, out_vaddr_i);
      compare("paddr", exp_paddr, out_paddr_i);
      compare("miss", 32'(!hit), 32'(out_miss_i));
      exp_pc = exp_pc + 32'd4;
      test_results++;
      n_results_o++;
   endtask

   // same vpn updates in place, else round-robin victim
   task automatic apply_fill();
      int slot;
      slot = -1;
      for (int i = 0; i < N_ENTRIES; i++) begin
         if (m_valid[i] && m_vpn[i] == fill_vpn_i) slot = i;
      end
      if (slot < 0) begin
         slot = m_victim;
         m_victim = (m_victim + 1) % N_ENTRIES;
      end
      m_valid[slot] = 1'b1;
      m_vpn[slot]   = fill_vpn_i;
      m_ppn[slot]   = fill_ppn_i;
   endtask

   task automatic report_test();
      if (cur_test != 3'd0) begin
         $display("test %s: %0d results, %0d errors",
                  test_name(cur_test), test_results, test_errors);
      end
   endtask

   always @(posedge clk_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < N_ENTRIES; i++) m_valid[i] = 1'b0;
         m_victim     = 0;
         exp_pc       = RESET_PC;
         cur_test     = 3'd0;
         test_results = 0;
         test_errors  = 0;
         n_results_o  = 0;
         n_errors_o   = 0;
         closed       = 1'b0;
      end else begin
         if (out_v_i && out_ready_i) check_output();
         if (redirect_v_i) exp_pc = redirect_pc_i;
         if (flush_i) begin
            for (int i = 0; i < N_ENTRIES; i++) m_valid[i] = 1'b0;
            m_victim = 0;   // flush wins over fill
         end else if (fill_v_i) begin
            apply_fill();
         end
         if (test_id_i != cur_test) begin
            report_test();
            cur_test     = test_id_i;
            test_results = 0;
            test_errors  = 0;
         end
         if (done_i && !closed) begin
            report_test();
            $display("totals: %0d results, %0d errors", n_results_o, n_errors_o);
            closed = 1'b1;
         end
      end
   end

endmodule

/* tb_top.sv */
/*
 * Testbench top for the fetch front end
 * LFSR stimulus, test sequence, cycle limit and final verdict
 */

`timescale 1ns/1ps

module tb_top;

   import addr_pkg::*;

   localparam int          N_ENTRIES = 4;
   localparam int          Q_DEPTH   = 4;
   localparam int          POOL_SIZE = 8;
   localparam logic [31:0] LFSR_SEED = 32'd71952;
   localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
   // about 300 results, each well under 60 cycles even with random stalls
   localparam int          EXPECTED_RESULTS = 300;
   localparam int          CYCLE_LIMIT      = EXPECTED_RESULTS * 60 + 2000;

   logic        clk;
   logic        rst_n;
   logic        fetch_en;
   logic        redirect_v;
   vaddr_t      redirect_pc;
   logic        fill_v;
   vpn_t        fill_vpn;
   ppn_t        fill_ppn;
   logic        flush;
   logic        out_ready;
   logic        out_v;
   vaddr_t      out_vaddr;
   paddr_t      out_paddr;
   logic        out_miss;
   logic [2:0]  test_id;
   logic        done;
   int          n_results;
   int          n_errors;
   int          cycles;
   logic [31:0] lfsr_q;
   vpn_t        vpn_pool [POOL_SIZE];

   tb_clkgen u_clkgen (
      .clk_o   (clk),
      .rst_n_o (rst_n)
   );

   fe_top #(
      .N_ENTRIES (N_ENTRIES),
      .Q_DEPTH   (Q_DEPTH)
   ) dut_i (
      .clk_i         (clk),
      .rst_n_i       (rst_n),
      .fetch_en_i    (fetch_en),
      .redirect_v_i  (redirect_v),
      .redirect_pc_i (redirect_pc),
      .fill_v_i      (fill_v),
      .fill_vpn_i    (fill_vpn),
      .fill_ppn_i    (fill_ppn),
      .flush_i       (flush),
      .out_v_o       (out_v),
      .out_vaddr_o   (out_vaddr),
      .out_paddr_o   (out_paddr),
      .out_miss_o    (out_miss),
      .out_ready_i   (out_ready)
   );

   tb_checker #(
      .N_ENTRIES (N_ENTRIES)
   ) u_checker (
      .clk_i         (clk),
      .rst_n_i       (rst_n),
      .test_id_i     (test_id),
      .done_i        (done),
      .redirect_v_i  (redirect_v),
      .redirect_pc_i (redirect_pc),
      .fill_v_i      (fill_v),
      .fill_vpn_i    (fill_vpn),
      .fill_ppn_i    (fill_ppn),
      .flush_i       (flush),
      .out_v_i       (out_v),
      .out_vaddr_i   (out_vaddr),
      .out_paddr_i   (out_paddr),
      .out_miss_i    (out_miss),
      .out_ready_i   (out_ready),
      .n_results_o   (n_results),
      .n_errors_o    (n_errors)
   );

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
   endfunction

   // one lfsr step per bit taken
   task automatic rand_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr_q[0]};
         lfsr_q = lfsr_next(lfsr_q);
      end
   endtask

   task automatic drive_fill(input vpn_t vpn, input ppn_t ppn);
      @(negedge clk);
      fill_v   = 1'b1;
      fill_vpn = vpn;
      fill_ppn = ppn;
      @(negedge clk);
      fill_v = 1'b0;
   endtask

   task automatic fill_random(input int first, input int last);
      logic [31:0] r;
      for (int i = first; i <= last; i++) begin
         rand_bits(20, r);
         drive_fill(vpn_pool[i], r[19:0]);
      end
   endtask

   task automatic do_flush();
      @(negedge clk);
      flush = 1'b1;
      @(negedge clk);
      flush = 1'b0;
   endtask

   // pipeline empty once the queue stays empty for 4 cycles
   task automatic drain();
      int quiet;
      quiet = 0;
      fetch_en  = 1'b0;
      out_ready = 1'b1;
      while (quiet < 4) begin
         @(negedge clk);
         quiet = out_v ? 0 : quiet + 1;
      end
   endtask

   task automatic run_fetch(input int n, input logic random_ready);
      int          base;
      logic [31:0] r;
      base = n_results;
      @(negedge clk);
      fetch_en = 1'b1;
      while (n_results < base + n) begin
         @(negedge clk);
         if (random_ready) begin
            rand_bits(1, r);
            out_ready = r[0];
         end
      end
      drain();
   endtask

   // redirect to a random word in the page, then fetch
   task automatic fetch_page(input vpn_t vpn, input int n, input logic random_ready);
      logic [31:0] r;
      rand_bits(10, r);
      @(negedge clk);
      redirect_v  = 1'b1;
      redirect_pc = {vpn, r[9:0], 2'b00};
      @(negedge clk);
      redirect_v = 1'b0;
      run_fetch(n, random_ready);
   endtask

   initial begin
      cycles = 0;
      while (cycles < CYCLE_LIMIT) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Simulation failed");
      $finish;
   end

   initial begin
      logic [31:0] r;
      fetch_en    = 1'b0;
      redirect_v  = 1'b0;
      redirect_pc = '0;
      fill_v      = 1'b0;
      fill_vpn    = '0;
      fill_ppn    = '0;
      flush       = 1'b0;
      out_ready   = 1'b1;
      test_id     = 3'd0;
      done        = 1'b0;
      lfsr_q      = LFSR_SEED;
      for (int i = 0; i < POOL_SIZE; i++) begin
         rand_bits(17, r);
         vpn_pool[i] = {r[16:0], 3'(i)};   // low bits keep the pool distinct
      end
      wait (rst_n === 1'b1);
      @(negedge clk);

      test_id = 3'd1;
      run_fetch(16, 1'b0);

      test_id = 3'd2;
      fill_random(0, 2);
      for (int i = 0; i < 4; i++) fetch_page(vpn_pool[i], 8, 1'b0);

      test_id = 3'd3;
      do_flush();
      fill_random(0, N_ENTRIES);
      for (int i = 0; i <= N_ENTRIES; i++) fetch_page(vpn_pool[i], 4, 1'b0);

      test_id = 3'd4;
      fill_random(2, 2);
      for (int i = 1; i <= N_ENTRIES; i++) fetch_page(vpn_pool[i], 4, 1'b0);

      test_id = 3'd5;
      do_flush();
      for (int i = 1; i <= N_ENTRIES; i++) fetch_page(vpn_pool[i], 4, 1'b0);

      test_id = 3'd6;
      fill_random(0, N_ENTRIES - 1);
      fetch_page(vpn_pool[0], 200, 1'b1);

      done = 1'b1;
      repeat (2) @(negedge clk);
      if (n_errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* tb.f */
addr_pkg.sv
tlb_pkg.sv
pc_gen.sv
itlb.sv
fetch_queue.sv
fe_top.sv
fe_assert.sv
tb_clkgen.sv
tb_checker.sv
tb_top.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_top
FILELIST  = tb.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
